// ==== logic/sort_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared sizes and the memory owner type of the sorter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package sort_pkg;

    parameter int default_data_width = 16;
    parameter int default_max_sort_length = 32;

    // Which client currently drives the working memory
    typedef enum logic [1:0] {
        owner_load   = 2'd0,
        owner_merge  = 2'd1,
        owner_unload = 2'd2
    } buffer_owner_t;

endpackage

`default_nettype wire

// ==== logic/run_memory.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two-bank working memory; the owner picks the client
// that reaches the write port and the read addresses
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module run_memory #(
    parameter int DATA_WIDTH = sort_pkg::default_data_width,
    parameter int MAX_SORT_LENGTH = sort_pkg::default_max_sort_length
) (
    input wire clock,
    input wire sort_pkg::buffer_owner_t owner,
    input wire load_we,
    input wire [$clog2(MAX_SORT_LENGTH)-1:0] load_addr,
    input wire [DATA_WIDTH-1:0] load_wdata,
    input wire merge_we,
    input wire merge_bank,
    input wire [$clog2(MAX_SORT_LENGTH)-1:0] merge_addr,
    input wire [DATA_WIDTH-1:0] merge_wdata,
    input wire fetch_bank,
    input wire [$clog2(MAX_SORT_LENGTH)-1:0] fetch_addr_a,
    input wire [$clog2(MAX_SORT_LENGTH)-1:0] fetch_addr_b,
    input wire unload_bank,
    input wire [$clog2(MAX_SORT_LENGTH)-1:0] unload_addr,
    output logic [DATA_WIDTH-1:0] rdata_a,
    output logic [DATA_WIDTH-1:0] rdata_b
);
    import sort_pkg::*;

    localparam int AW = $clog2(MAX_SORT_LENGTH);

    logic [DATA_WIDTH-1:0] mem [2][MAX_SORT_LENGTH];
    logic wr_en;
    logic wr_bank;
    logic [AW-1:0] wr_addr;
    logic [DATA_WIDTH-1:0] wr_data;
    logic rd_bank;
    logic [AW-1:0] rd_addr_a;

    always_comb begin
        wr_en = 1'b0;
        wr_bank = merge_bank;
        wr_addr = merge_addr;
        wr_data = merge_wdata;
        if (owner == owner_load) begin
            wr_en = load_we;
            wr_bank = 1'b0;
            wr_addr = load_addr;
            wr_data = load_wdata;
        end else if (owner == owner_merge) begin
            wr_en = merge_we;
        end
    end

    // Unload reads share port A with the fetcher
    assign rd_bank = (owner == owner_unload) ? unload_bank : fetch_bank;
    assign rd_addr_a = (owner == owner_unload) ? unload_addr : fetch_addr_a;

    always_ff @(posedge clock) begin
        if (wr_en) begin
            mem[wr_bank][wr_addr] <= wr_data;
        end
        rdata_a <= mem[rd_bank][rd_addr_a];
        rdata_b <= mem[rd_bank][fetch_addr_b];
    end

endmodule

`default_nettype wire

// ==== logic/sort_loader.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Input side, writes the incoming block into bank 0
// and reports its length when the block ends
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module sort_loader #(
    parameter int DATA_WIDTH = sort_pkg::default_data_width,
    parameter int MAX_SORT_LENGTH = sort_pkg::default_max_sort_length
) (
    input wire clock,
    input wire rst,
    input wire sort_pkg::buffer_owner_t owner,
    input wire in_valid,
    input wire [DATA_WIDTH-1:0] in_data,
    input wire in_last,
    output logic in_ready,
    output logic load_we,
    output logic [$clog2(MAX_SORT_LENGTH)-1:0] load_addr,
    output logic [DATA_WIDTH-1:0] load_wdata,
    output logic load_done,
    output logic [$clog2(MAX_SORT_LENGTH):0] block_length
);
    import sort_pkg::*;

    localparam int AW = $clog2(MAX_SORT_LENGTH);

    logic [AW-1:0] count;
    logic block_end;

    // A full memory also closes the block
    assign block_end = in_last || (count == AW'(MAX_SORT_LENGTH - 1));
    assign load_we = in_valid && in_ready;
    assign load_addr = count;
    assign load_wdata = in_data;

    always_ff @(posedge clock) begin
        if (rst) begin
            in_ready <= 1'b0;
            load_done <= 1'b0;
            count <= '0;
        end else begin
            load_done <= load_we && block_end;
            // Stay low until the sequencer has taken the memory away
            in_ready <= (owner == owner_load) && !load_done && !(load_we && block_end);
            if (load_we) begin
                count <= block_end ? '0 : count + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (load_we && block_end) begin
            block_length <= {1'b0, count} + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== logic/run_fetcher.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reads runs A and B from the source bank and offers
// each head word as a valid/ready stream
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module run_fetcher #(
    parameter int DATA_WIDTH = sort_pkg::default_data_width,
    parameter int MAX_SORT_LENGTH = sort_pkg::default_max_sort_length
) (
    input wire clock,
    input wire rst,
    input wire merge_start,
    input wire [$clog2(MAX_SORT_LENGTH)-1:0] run_base_a,
    input wire [$clog2(MAX_SORT_LENGTH):0] run_size_a,
    input wire [$clog2(MAX_SORT_LENGTH)-1:0] run_base_b,
    input wire [$clog2(MAX_SORT_LENGTH):0] run_size_b,
    input wire [DATA_WIDTH-1:0] rdata_a,
    input wire [DATA_WIDTH-1:0] rdata_b,
    input wire a_ready,
    input wire b_ready,
    output logic [$clog2(MAX_SORT_LENGTH)-1:0] fetch_addr_a,
    output logic [$clog2(MAX_SORT_LENGTH)-1:0] fetch_addr_b,
    output logic a_valid,
    output logic [DATA_WIDTH-1:0] a_data,
    output logic b_valid,
    output logic [DATA_WIDTH-1:0] b_data
);

    localparam int AW = $clog2(MAX_SORT_LENGTH);
    localparam int CW = AW + 1;

    // Index 0 is run A, index 1 is run B
    logic [AW-1:0] base [2];
    logic [CW-1:0] size [2];
    logic [DATA_WIDTH-1:0] rdata [2];
    logic ready [2];
    logic [AW-1:0] ptr [2];
    logic [CW-1:0] remaining [2];
    logic pending [2];
    logic issue [2];
    logic head_valid [2];
    logic [DATA_WIDTH-1:0] head [2];

    assign base[0] = run_base_a;
    assign base[1] = run_base_b;
    assign size[0] = run_size_a;
    assign size[1] = run_size_b;
    assign rdata[0] = rdata_a;
    assign rdata[1] = rdata_b;
    assign ready[0] = a_ready;
    assign ready[1] = b_ready;

    assign fetch_addr_a = ptr[0];
    assign fetch_addr_b = ptr[1];
    assign a_valid = head_valid[0];
    assign a_data = head[0];
    assign b_valid = head_valid[1];
    assign b_data = head[1];

    for (genvar i = 0; i < 2; i++) begin : g_run
        // A read goes out only when the head slot is empty and nothing is in flight
        assign issue[i] = !merge_start && !head_valid[i] && !pending[i]
                          && (remaining[i] != '0);

        always_ff @(posedge clock) begin
            if (rst) begin
                head_valid[i] <= 1'b0;
                pending[i] <= 1'b0;
                remaining[i] <= '0;
            end else if (merge_start) begin
                head_valid[i] <= 1'b0;
                pending[i] <= 1'b0;
                remaining[i] <= size[i];
            end else begin
                pending[i] <= issue[i];
                if (issue[i]) begin
                    remaining[i] <= remaining[i] - 1'b1;
                end
                if (pending[i]) begin
                    head_valid[i] <= 1'b1;
                end else if (head_valid[i] && ready[i]) begin
                    head_valid[i] <= 1'b0;
                end
            end
        end

        always_ff @(posedge clock) begin
            if (merge_start) begin
                ptr[i] <= base[i];
            end else if (issue[i]) begin
                ptr[i] <= ptr[i] + 1'b1;
            end
            if (pending[i]) begin
                head[i] <= rdata[i];
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/merging_core.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Merges two sorted runs into one ascending stream and
// flags the end of each pair with merge_done
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module merging_core #(
    parameter int DATA_WIDTH = sort_pkg::default_data_width,
    parameter int MAX_SORT_LENGTH = sort_pkg::default_max_sort_length
) (
    input wire clock,
    input wire rst,
    input wire merge_start,
    input wire [$clog2(MAX_SORT_LENGTH):0] run_size_a,
    input wire [$clog2(MAX_SORT_LENGTH):0] run_size_b,
    input wire a_valid,
    input wire [DATA_WIDTH-1:0] a_data,
    input wire b_valid,
    input wire [DATA_WIDTH-1:0] b_data,
    output logic a_ready,
    output logic b_ready,
    output logic merged_valid,
    output logic [DATA_WIDTH-1:0] merged_data,
    output logic merge_done
);

    localparam int CW = $clog2(MAX_SORT_LENGTH) + 1;

    typedef enum logic [1:0] {
        st_idle   = 2'd0,
        st_both   = 2'd1,
        st_copy_a = 2'd2,
        st_copy_b = 2'd3
    } state_t;

    state_t state;
    logic [CW-1:0] count_a;
    logic [CW-1:0] count_b;
    logic b_smaller;
    logic last_a;
    logic last_b;

    // Equal heads go to run A, which keeps the sort stable
    assign b_smaller = b_data < a_data;
    assign last_a = (count_a + 1'b1) == run_size_a;
    assign last_b = (count_b + 1'b1) == run_size_b;

    always_comb begin
        a_ready = 1'b0;
        b_ready = 1'b0;
        merged_valid = 1'b0;
        merged_data = a_data;
        case (state)
            st_both: begin
                merged_valid = a_valid && b_valid;
                a_ready = merged_valid && !b_smaller;
                b_ready = merged_valid && b_smaller;
                if (b_smaller) begin
                    merged_data = b_data;
                end
            end
            st_copy_a: begin
                merged_valid = a_valid;
                a_ready = a_valid;
            end
            st_copy_b: begin
                merged_valid = b_valid;
                b_ready = b_valid;
                merged_data = b_data;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            state <= st_idle;
            merge_done <= 1'b0;
            count_a <= '0;
            count_b <= '0;
        end else begin
            merge_done <= 1'b0;
            if (a_ready) begin
                count_a <= count_a + 1'b1;
            end
            if (b_ready) begin
                count_b <= count_b + 1'b1;
            end
            case (state)
                st_idle: begin
                    count_a <= '0;
                    count_b <= '0;
                    if (merge_start) begin
                        // The odd last run of a pass has no partner
                        state <= (run_size_b == '0) ? st_copy_a : st_both;
                    end
                end
                st_both: begin
                    if (a_ready && last_a) begin
                        state <= st_copy_b;
                    end else if (b_ready && last_b) begin
                        state <= st_copy_a;
                    end
                end
                st_copy_a: begin
                    if (a_ready && last_a) begin
                        state <= st_idle;
                        merge_done <= 1'b1;
                    end
                end
                default: begin
                    if (b_ready && last_b) begin
                        state <= st_idle;
                        merge_done <= 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/merge_sequencer.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Runs the bottom-up merge passes and hands the memory
// from loader to merge and on to the unloader
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module merge_sequencer #(
    parameter int DATA_WIDTH = sort_pkg::default_data_width,
    parameter int MAX_SORT_LENGTH = sort_pkg::default_max_sort_length
) (
    input wire clock,
    input wire rst,
    input wire load_done,
    input wire [$clog2(MAX_SORT_LENGTH):0] block_length,
    input wire merged_valid,
    input wire [DATA_WIDTH-1:0] merged_data,
    input wire merge_done,
    input wire unload_done,
    output sort_pkg::buffer_owner_t owner,
    output logic merge_start,
    output logic [$clog2(MAX_SORT_LENGTH)-1:0] run_base_a,
    output logic [$clog2(MAX_SORT_LENGTH):0] run_size_a,
    output logic [$clog2(MAX_SORT_LENGTH)-1:0] run_base_b,
    output logic [$clog2(MAX_SORT_LENGTH):0] run_size_b,
    output logic fetch_bank,
    output logic merge_we,
    output logic merge_bank,
    output logic [$clog2(MAX_SORT_LENGTH)-1:0] merge_addr,
    output logic [DATA_WIDTH-1:0] merge_wdata,
    output logic result_bank
);
    import sort_pkg::*;

    localparam int AW = $clog2(MAX_SORT_LENGTH);
    localparam int CW = AW + 1;

    typedef enum logic [1:0] {
        st_load   = 2'd0,
        st_start  = 2'd1,
        st_wait   = 2'd2,
        st_unload = 2'd3
    } state_t;

    state_t state;
    logic [CW-1:0] width;
    logic [CW-1:0] pair_base;
    logic [CW-1:0] a_end;
    logic [CW-1:0] b_end;
    logic [CW-1:0] next_base;
    logic [CW-1:0] next_width;
    logic src_bank;
    logic [AW-1:0] wr_addr;

    // Run boundaries clipped at the block length
    always_comb begin
        a_end = pair_base + width;
        if (a_end > block_length) begin
            a_end = block_length;
        end
        b_end = a_end + width;
        if (b_end > block_length) begin
            b_end = block_length;
        end
        next_width = width << 1;
        next_base = pair_base + next_width;
    end

    // Merged words land in the other bank the cycle they appear
    assign fetch_bank = src_bank;
    assign merge_bank = ~src_bank;
    assign merge_we = merged_valid;
    assign merge_addr = wr_addr;
    assign merge_wdata = merged_data;

    always_ff @(posedge clock) begin
        if (rst) begin
            state <= st_load;
            owner <= owner_load;
            merge_start <= 1'b0;
            width <= '0;
            pair_base <= '0;
            src_bank <= 1'b0;
            result_bank <= 1'b0;
            wr_addr <= '0;
        end else begin
            merge_start <= 1'b0;
            if (merged_valid) begin
                wr_addr <= wr_addr + 1'b1;
            end
            case (state)
                st_load: begin
                    if (load_done) begin
                        width <= CW'(1);
                        pair_base <= '0;
                        src_bank <= 1'b0;
                        wr_addr <= '0;
                        if (block_length == CW'(1)) begin
                            result_bank <= 1'b0;
                            owner <= owner_unload;
                            state <= st_unload;
                        end else begin
                            owner <= owner_merge;
                            state <= st_start;
                        end
                    end
                end
                st_start: begin
                    merge_start <= 1'b1;
                    state <= st_wait;
                end
                st_wait: begin
                    if (merge_done) begin
                        state <= st_start;
                        if (next_base >= block_length) begin
                            // Pass finished, so widen the runs and swap banks
                            width <= next_width;
                            pair_base <= '0;
                            src_bank <= ~src_bank;
                            wr_addr <= '0;
                            if (next_width >= block_length) begin
                                result_bank <= ~src_bank;
                                owner <= owner_unload;
                                state <= st_unload;
                            end
                        end else begin
                            pair_base <= next_base;
                        end
                    end
                end
                default: begin
                    if (unload_done) begin
                        owner <= owner_load;
                        state <= st_load;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == st_start) begin
            run_base_a <= pair_base[AW-1:0];
            run_size_a <= a_end - pair_base;
            run_base_b <= a_end[AW-1:0];
            run_size_b <= b_end - a_end;
        end
    end

endmodule

`default_nettype wire

// ==== logic/sort_unloader.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Output side, streams the sorted block from the result
// bank and holds its word under back-pressure
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module sort_unloader #(
    parameter int DATA_WIDTH = sort_pkg::default_data_width,
    parameter int MAX_SORT_LENGTH = sort_pkg::default_max_sort_length
) (
    input wire clock,
    input wire rst,
    input wire sort_pkg::buffer_owner_t owner,
    input wire result_bank,
    input wire [$clog2(MAX_SORT_LENGTH):0] block_length,
    input wire [DATA_WIDTH-1:0] rdata_a,
    input wire out_ready,
    output logic unload_bank,
    output logic [$clog2(MAX_SORT_LENGTH)-1:0] unload_addr,
    output logic out_valid,
    output logic [DATA_WIDTH-1:0] out_data,
    output logic out_last,
    output logic unload_done
);
    import sort_pkg::*;

    localparam int AW = $clog2(MAX_SORT_LENGTH);
    localparam int CW = AW + 1;

    logic active;
    logic [CW-1:0] index;
    logic rd_ok;
    logic fire;
    logic load_out;

    assign active = owner == owner_unload;
    assign fire = out_valid && out_ready;
    // rd_ok marks that rdata_a already holds the word at index
    assign load_out = active && rd_ok && (index != block_length) && (!out_valid || out_ready);
    assign unload_bank = result_bank;
    assign unload_addr = index[AW-1:0];
    assign unload_done = fire && out_last;

    always_ff @(posedge clock) begin
        if (rst || !active) begin
            out_valid <= 1'b0;
            index <= '0;
            rd_ok <= 1'b0;
        end else begin
            rd_ok <= !load_out;
            if (load_out) begin
                index <= index + 1'b1;
                out_valid <= 1'b1;
            end else if (fire) begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (load_out) begin
            out_data <= rdata_a;
            out_last <= index == (block_length - 1'b1);
        end
    end

endmodule

`default_nettype wire

// ==== logic/merge_sorter.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Top level of the block merge sorter, wiring only
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module merge_sorter #(
    parameter int DATA_WIDTH = sort_pkg::default_data_width,
    parameter int MAX_SORT_LENGTH = sort_pkg::default_max_sort_length
) (
    input wire clock,
    input wire rst,
    input wire in_valid,
    input wire [DATA_WIDTH-1:0] in_data,
    input wire in_last,
    input wire out_ready,
    output logic in_ready,
    output logic out_valid,
    output logic [DATA_WIDTH-1:0] out_data,
    output logic out_last
);
    import sort_pkg::*;

    localparam int AW = $clog2(MAX_SORT_LENGTH);

    buffer_owner_t owner;
    logic load_we, load_done, merge_we, merge_bank, fetch_bank;
    logic unload_bank, unload_done, result_bank, merge_start, merge_done;
    logic a_valid, a_ready, b_valid, b_ready, merged_valid;
    logic [AW-1:0] load_addr, merge_addr, fetch_addr_a, fetch_addr_b, unload_addr;
    logic [AW-1:0] run_base_a, run_base_b;
    logic [AW:0] block_length, run_size_a, run_size_b;
    logic [DATA_WIDTH-1:0] load_wdata, merge_wdata, rdata_a, rdata_b;
    logic [DATA_WIDTH-1:0] a_data, b_data, merged_data;

    sort_loader #(.DATA_WIDTH(DATA_WIDTH), .MAX_SORT_LENGTH(MAX_SORT_LENGTH)) loader_inst (
        .clock, .rst, .owner, .in_valid, .in_data, .in_last, .in_ready,
        .load_we, .load_addr, .load_wdata, .load_done, .block_length
    );

    run_memory #(.DATA_WIDTH(DATA_WIDTH), .MAX_SORT_LENGTH(MAX_SORT_LENGTH)) memory_inst (
        .clock, .owner, .load_we, .load_addr, .load_wdata,
        .merge_we, .merge_bank, .merge_addr, .merge_wdata,
        .fetch_bank, .fetch_addr_a, .fetch_addr_b, .unload_bank, .unload_addr,
        .rdata_a, .rdata_b
    );

    run_fetcher #(.DATA_WIDTH(DATA_WIDTH), .MAX_SORT_LENGTH(MAX_SORT_LENGTH)) fetcher_inst (
        .clock, .rst, .merge_start, .run_base_a, .run_size_a, .run_base_b, .run_size_b,
        .rdata_a, .rdata_b, .a_ready, .b_ready, .fetch_addr_a, .fetch_addr_b,
        .a_valid, .a_data, .b_valid, .b_data
    );

    merging_core #(.DATA_WIDTH(DATA_WIDTH), .MAX_SORT_LENGTH(MAX_SORT_LENGTH)) core_inst (
        .clock, .rst, .merge_start, .run_size_a, .run_size_b,
        .a_valid, .a_data, .b_valid, .b_data, .a_ready, .b_ready,
        .merged_valid, .merged_data, .merge_done
    );

    merge_sequencer #(.DATA_WIDTH(DATA_WIDTH), .MAX_SORT_LENGTH(MAX_SORT_LENGTH)) seq_inst (
        .clock, .rst, .load_done, .block_length, .merged_valid, .merged_data,
        .merge_done, .unload_done, .owner, .merge_start, .run_base_a, .run_size_a,
        .run_base_b, .run_size_b, .fetch_bank, .merge_we, .merge_bank, .merge_addr,
        .merge_wdata, .result_bank
    );

    sort_unloader #(.DATA_WIDTH(DATA_WIDTH), .MAX_SORT_LENGTH(MAX_SORT_LENGTH)) unloader_inst (
        .clock, .rst, .owner, .result_bank, .block_length, .rdata_a, .out_ready,
        .unload_bank, .unload_addr, .out_valid, .out_data, .out_last, .unload_done
    );

endmodule

`default_nettype wire

// ==== sim/merge_sorter_props.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Stream protocol assertions that are bound into merge_sorter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module merge_sorter_props #(
    parameter int DATA_WIDTH = 16
) (
    input wire clock,
    input wire rst,
    input wire in_ready,
    input wire out_valid,
    input wire out_ready,
    input wire [DATA_WIDTH-1:0] out_data
);

    // Count of failed assertions so far
    int failures = 0;

    // A stalled output word must not move or vanish
    property output_held_under_stall;
        @(posedge clock) disable iff (rst)
            (out_valid && !out_ready) |=> (out_valid && $stable(out_data));
    endproperty

    // Loading and unloading never overlap
    property input_output_exclusive;
        @(posedge clock) disable iff (rst)
            !(in_ready && out_valid);
    endproperty

    property output_idle_after_reset;
        @(posedge clock) rst |=> !out_valid;
    endproperty

    assert property (output_held_under_stall)
        else begin
            $error("out_valid or out_data changed while stalled");
            failures++;
        end

    assert property (input_output_exclusive)
        else begin
            $error("in_ready and out_valid high in the same cycle");
            failures++;
        end

    assert property (output_idle_after_reset)
        else begin
            $error("out_valid high in the cycle after reset");
            failures++;
        end

endmodule

`default_nettype wire

// ==== sim/merge_sorter_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for merge_sorter that checks random blocks
// against a queue sorting model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module merge_sorter_tb;

    localparam int DATA_WIDTH = 16;
    localparam int MAX_LEN = 32;
    localparam int NUM_BLOCKS = 40;
    localparam int CLOCK_PERIOD = 20;
    localparam int WATCHDOG_CYCLES = NUM_BLOCKS * (MAX_LEN * 6 * 8 + 200);

    logic clock;
    logic rst;
    logic in_valid;
    logic [DATA_WIDTH-1:0] in_data;
    logic in_last;
    logic out_ready;
    logic in_ready;
    logic out_valid;
    logic [DATA_WIDTH-1:0] out_data;
    logic out_last;

    integer seed;
    logic [DATA_WIDTH-1:0] block_q[$];
    logic [DATA_WIDTH-1:0] expected_q[$];

    merge_sorter #(
        .DATA_WIDTH(DATA_WIDTH),
        .MAX_SORT_LENGTH(MAX_LEN)
    ) merge_sorter_inst (
        .clock(clock),
        .rst(rst),
        .in_valid(in_valid),
        .in_data(in_data),
        .in_last(in_last),
        .out_ready(out_ready),
        .in_ready(in_ready),
        .out_valid(out_valid),
        .out_data(out_data),
        .out_last(out_last)
    );

    bind merge_sorter merge_sorter_props #(.DATA_WIDTH(DATA_WIDTH)) props_inst (
        .clock(clock),
        .rst(rst),
        .in_ready(in_ready),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .out_data(out_data)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLOCK_PERIOD);
        $display("Watchdog expired: the sorter hung and stopped delivering blocks");
        $display("Done: errors found");
        $fatal(1, "watchdog timeout");
    end

    // A failed protocol assertion ends the run at once
    initial begin
        wait (merge_sorter_inst.props_inst.failures != 0);
        $display("A stream protocol assertion on the sorter failed");
        $display("Done: errors found");
        $fatal(1, "assertion failure");
    end

    function automatic int rand_range(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s is %0h, expected %0h", $time, what, actual,
                     expected);
            $display("Done: errors found");
            $fatal(1, "check failed");
        end
    endtask

    // Mode 0 spans the full range, 1 forces duplicates, 2 mixes in 0 and all ones
    function automatic logic [DATA_WIDTH-1:0] draw_value(input int mode);
        int pick;
        if (mode == 1) begin
            return 16'h1000 + rand_range(4);
        end
        if (mode == 2) begin
            pick = rand_range(3);
            if (pick == 0) begin
                return '0;
            end
            if (pick == 1) begin
                return '1;
            end
        end
        return rand_range(1 << DATA_WIDTH);
    endfunction

    // The first blocks hit the corner lengths, the rest are random
    function automatic int pick_length(input int block);
        case (block)
            0: return 1;
            1: return MAX_LEN;
            2: return 16;
            3: return 13;
            4: return 2;
            5: return MAX_LEN - 1;
            default: return 1 + rand_range(MAX_LEN);
        endcase
    endfunction

    // Insertion into an ordered queue gives the ascending reference
    task automatic build_expected();
        int pos;
        expected_q = {};
        foreach (block_q[i]) begin
            pos = 0;
            while (pos < expected_q.size() && expected_q[pos] <= block_q[i]) begin
                pos++;
            end
            expected_q.insert(pos, block_q[i]);
        end
    endtask

    task automatic send_block(input int len);
        int idx;
        idx = 0;
        while (idx < len) begin
            @(posedge clock);
            #2;
            if (rand_range(4) == 0) begin
                in_valid = 1'b0;
            end else begin
                in_valid = 1'b1;
                in_data = block_q[idx];
                // A full block may also end without in_last
                in_last = (idx == len - 1) && !(len == MAX_LEN && rand_range(2) == 0);
            end
            @(negedge clock);
            if (in_valid && in_ready) begin
                idx++;
            end
        end
        @(posedge clock);
        #2;
        in_valid = 1'b0;
        in_last = 1'b0;
    endtask

    task automatic receive_block(input int len);
        int count;
        logic got_last;
        count = 0;
        got_last = 1'b0;
        while (!got_last) begin
            @(posedge clock);
            #2;
            out_ready = rand_range(4) != 0;
            @(negedge clock);
            if (count > 0) begin
                check_value("in_ready during unload", in_ready, 1'b0);
            end
            if (out_valid && out_ready) begin
                check_value("out_data", out_data, expected_q[count]);
                check_value("out_last", out_last, count == len - 1);
                got_last = out_last;
                count++;
            end
        end
        @(posedge clock);
        #2;
        out_ready = 1'b0;
        // The loader takes the next block one cycle after the final transfer
        @(posedge clock);
        @(negedge clock);
        check_value("in_ready after block", in_ready, 1'b1);
    endtask

    initial begin
        int len;
        int mode;
        seed = 32'h8683_6e99;
        rst = 1'b1;
        in_valid = 1'b0;
        in_data = '0;
        in_last = 1'b0;
        out_ready = 1'b0;
        repeat (3) @(posedge clock);
        #2;
        rst = 1'b0;
        @(negedge clock);
        check_value("out_valid after reset", out_valid, 1'b0);
        @(posedge clock);
        @(negedge clock);
        check_value("in_ready after reset", in_ready, 1'b1);

        for (int b = 0; b < NUM_BLOCKS; b++) begin
            len = pick_length(b);
            mode = b % 3;
            block_q = {};
            for (int i = 0; i < len; i++) begin
                block_q.push_back(draw_value(mode));
            end
            build_expected();
            fork
                send_block(len);
                receive_block(len);
            join
        end

        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== merge_sorter.f ====
logic/sort_pkg.sv
logic/run_memory.sv
logic/sort_loader.sv
logic/run_fetcher.sv
logic/merging_core.sv
logic/merge_sequencer.sv
logic/sort_unloader.sv
logic/merge_sorter.sv
sim/merge_sorter_props.sv
sim/merge_sorter_tb.sv
